// File: verilog/jtag_master_defines.svh
// Register map and sizes; JM_MEM_BYTES is the only size meant to change, bus addresses are 16 bit
`ifndef JTAG_MASTER_DEFINES_SVH
`define JTAG_MASTER_DEFINES_SVH

`define JM_MEM_BYTES     16                       // Bytes in each scan memory
`define JM_MEM_BITS      (8 * `JM_MEM_BYTES)
`define JM_VERSION       8'd1
`define JM_TLR_CYCLES    6                        // TCK cycles of the reset sequence

`define JM_REG_RST       16'd0
`define JM_REG_START     16'd1
`define JM_REG_BITS_LO   16'd3
`define JM_REG_BITS_HI   16'd4
`define JM_REG_WORDS_LO  16'd9
`define JM_REG_WORDS_HI  16'd10
`define JM_REG_OPCODE    16'd11
`define JM_REG_MEMSZ_LO  16'd14
`define JM_REG_MEMSZ_HI  16'd15

`define JM_TDI_BASE      16'd16
`define JM_TDO_BASE      (`JM_TDI_BASE + 16'(`JM_MEM_BYTES))

`endif

// File: verilog/jtag_master_pkg.sv
// Shared types; bit_addr_t follows JM_MEM_BYTES, the TAP encoding is fixed at 4 bits
`include "jtag_master_defines.svh"

package jtag_master_pkg;

    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_byte_t;
    typedef logic [15:0] bit_cnt_t;
    typedef logic [15:0] word_cnt_t;

    // Bit index into one scan memory
    typedef logic [$clog2(`JM_MEM_BITS)-1:0] bit_addr_t;

    typedef enum logic [3:0] {
        test_logic_reset = 4'd0,
        run_test_idle    = 4'd1,
        select_dr        = 4'd2,
        capture_dr       = 4'd3,
        shift_dr         = 4'd4,
        exit1_dr         = 4'd5,
        pause_dr         = 4'd6,   // Not used
        exit2_dr         = 4'd7,   // Not used
        update_dr        = 4'd8,
        select_ir        = 4'd9,
        capture_ir       = 4'd10,
        shift_ir         = 4'd11,
        exit1_ir         = 4'd12,
        pause_ir         = 4'd13,  // Not used
        exit2_ir         = 4'd14,  // Not used
        update_ir        = 4'd15
    } tap_state_t;

    typedef enum logic {
        ir_scan = 1'b0,
        dr_scan = 1'b1
    } scan_op_t;

endpackage

// File: verilog/jtag_master_if.sv
// Internal links of the core; both sides run on jtag_clk, strobes are one cycle wide
`timescale 1ns/1ps

// Scan setup from the register bank to the TAP controller
interface jtag_cfg_if;
    jtag_master_pkg::bit_cnt_t  bit_count;
    jtag_master_pkg::word_cnt_t word_count;
    jtag_master_pkg::scan_op_t  opcode;
    logic                       start;     // Write to register 1
    logic                       soft_rst;  // Write to register 0
    logic                       done;      // End of reset sequence or last word

    modport regs (
        output bit_count, word_count, opcode, start, soft_rst,
        input  done
    );

    modport tap (
        input  bit_count, word_count, opcode, start, soft_rst,
        output done
    );
endinterface

// Bit-wide scan port of the TDI and TDO memories
interface jtag_scan_if;
    jtag_master_pkg::bit_addr_t bit_addr;
    logic                       cap_en;
    logic                       cap_bit;
    logic                       tdi_bit;   // Combinational read at bit_addr

    modport tap (
        output bit_addr, cap_en, cap_bit,
        input  tdi_bit
    );

    modport mem (
        input  bit_addr, cap_en, cap_bit,
        output tdi_bit
    );
endinterface

// File: verilog/jtag_master_regs.sv
// Bus registers; a write to register 0 also restores every register to its default
`timescale 1ns/1ps
`include "jtag_master_defines.svh"

module jtag_master_regs (
    input  logic                       jtag_clk,
    input  logic                       rst_sync,
    input  jtag_master_pkg::bus_addr_t bus_add,
    input  jtag_master_pkg::bus_byte_t bus_data_in,
    input  logic                       bus_wr,
    input  logic                       bus_rd,
    output jtag_master_pkg::bus_byte_t bus_data_out,
    input  jtag_master_pkg::bus_byte_t tdo_byte,
    jtag_cfg_if.regs                   cfg
);

    localparam logic [15:0] mem_size = 16'(`JM_MEM_BYTES);

    jtag_master_pkg::bit_cnt_t  bit_count;
    jtag_master_pkg::word_cnt_t word_count;
    jtag_master_pkg::scan_op_t  opcode;
    logic                       rst;
    logic                       conf_done;

    assign cfg.soft_rst = bus_wr && (bus_add == `JM_REG_RST);
    assign cfg.start    = bus_wr && (bus_add == `JM_REG_START);
    assign rst          = rst_sync || cfg.soft_rst;

    assign cfg.bit_count  = bit_count;
    assign cfg.word_count = word_count;
    assign cfg.opcode     = opcode;

    always_ff @(posedge jtag_clk)
    begin
        if (rst)
        begin
            bit_count  <= jtag_master_pkg::bit_cnt_t'(`JM_MEM_BITS);  // Whole memory, one word
            word_count <= 16'd1;
            opcode     <= jtag_master_pkg::dr_scan;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                `JM_REG_BITS_LO:  bit_count[7:0]   <= bus_data_in;
                `JM_REG_BITS_HI:  bit_count[15:8]  <= bus_data_in;
                `JM_REG_WORDS_LO: word_count[7:0]  <= bus_data_in;
                `JM_REG_WORDS_HI: word_count[15:8] <= bus_data_in;
                `JM_REG_OPCODE:   opcode <= jtag_master_pkg::scan_op_t'(bus_data_in[0]);
                default: ;
            endcase
        end
    end

    // Sticky until the next start or reset
    always_ff @(posedge jtag_clk)
    begin
        if (rst || cfg.start)
            conf_done <= 1'b0;
        else if (cfg.done)
            conf_done <= 1'b1;
    end

    // Read data is latched at the read and held until the next one
    always_ff @(posedge jtag_clk)
    begin
        if (bus_rd)
        begin
            case (bus_add)
                `JM_REG_RST:      bus_data_out <= `JM_VERSION;
                `JM_REG_START:    bus_data_out <= {7'b0, conf_done};
                `JM_REG_BITS_LO:  bus_data_out <= bit_count[7:0];
                `JM_REG_BITS_HI:  bus_data_out <= bit_count[15:8];
                `JM_REG_WORDS_LO: bus_data_out <= word_count[7:0];
                `JM_REG_WORDS_HI: bus_data_out <= word_count[15:8];
                `JM_REG_OPCODE:   bus_data_out <= {7'b0, opcode};
                `JM_REG_MEMSZ_LO: bus_data_out <= mem_size[7:0];
                `JM_REG_MEMSZ_HI: bus_data_out <= mem_size[15:8];
                default:          bus_data_out <= tdo_byte;  // Zero outside the memory windows
            endcase
        end
    end

    // No start while the reset pin is high
    a_start_no_reset: assert property (
        @(posedge jtag_clk) cfg.start |-> !rst_sync
    );

endmodule

// File: verilog/jtag_scan_mem.sv
// TDI and TDO memories of JM_MEM_BYTES each; bit i sits in byte i/8 at position 7 - i%8
`timescale 1ns/1ps
`include "jtag_master_defines.svh"

module jtag_scan_mem (
    input  logic                       jtag_clk,
    input  jtag_master_pkg::bus_addr_t bus_add,
    input  jtag_master_pkg::bus_byte_t bus_data_in,
    input  logic                       bus_wr,
    output jtag_master_pkg::bus_byte_t tdo_byte,
    jtag_scan_if.mem                   scan
);

    localparam int byte_aw = $bits(jtag_master_pkg::bit_addr_t) - 3;

    // Byte-wide storage, so the MSB of a byte is its first scan bit
    jtag_master_pkg::bus_byte_t tdi_mem [`JM_MEM_BYTES];
    jtag_master_pkg::bus_byte_t tdo_mem [`JM_MEM_BYTES];

    jtag_master_pkg::bus_addr_t tdi_off;
    jtag_master_pkg::bus_addr_t tdo_off;
    logic                       in_tdi;
    logic                       in_tdo;
    logic                       addr_ok;
    logic [byte_aw-1:0]         scan_byte;
    logic [2:0]                 scan_pos;

    assign tdi_off = bus_add - `JM_TDI_BASE;
    assign tdo_off = bus_add - `JM_TDO_BASE;
    assign in_tdi  = (bus_add >= `JM_TDI_BASE) && (bus_add < `JM_TDO_BASE);
    assign in_tdo  = (bus_add >= `JM_TDO_BASE) && (tdo_off < 16'(`JM_MEM_BYTES));

    assign addr_ok   = 32'(scan.bit_addr) < `JM_MEM_BITS;
    assign scan_byte = scan.bit_addr[byte_aw+2:3];
    assign scan_pos  = ~scan.bit_addr[2:0];   // Index 0 of a byte is bit 7

    always_ff @(posedge jtag_clk)
    begin
        if (bus_wr && in_tdi)
            tdi_mem[tdi_off[byte_aw-1:0]] <= bus_data_in;
        if (scan.cap_en && addr_ok)
            tdo_mem[scan_byte][scan_pos] <= scan.cap_bit;
    end

    assign scan.tdi_bit = addr_ok ? tdi_mem[scan_byte][scan_pos] : 1'b0;

    always_comb
    begin
        if (in_tdi)
            tdo_byte = tdi_mem[tdi_off[byte_aw-1:0]];
        else if (in_tdo)
            tdo_byte = tdo_mem[tdo_off[byte_aw-1:0]];
        else
            tdo_byte = 8'h00;
    end

    // Word and bit counts of the TAP side must fit the memory
    a_cap_in_range: assert property (@(posedge jtag_clk) scan.cap_en |-> addr_ok);

endmodule

// File: verilog/jtag_tap_ctrl.sv
// TAP sequencer; TMS, TDI and sen change on the falling clock edge, Pause states are never used
`timescale 1ns/1ps
`include "jtag_master_defines.svh"

module jtag_tap_ctrl (
    input  logic    jtag_clk,
    input  logic    rst_sync,
    jtag_cfg_if.tap cfg,
    jtag_scan_if.tap scan,
    input  logic    tdo,
    output logic    tck,
    output logic    tms,
    output logic    tdi,
    output logic    sen,
    output logic    sld
);

    jtag_master_pkg::tap_state_t state;
    jtag_master_pkg::tap_state_t next_state;
    jtag_master_pkg::bit_cnt_t   bit_cnt;
    jtag_master_pkg::word_cnt_t  word_cnt;
    logic [2:0]                  reset_cnt;
    logic [31:0]                 addr_full;
    logic [1:0]                  sen_hist;
    logic rst, busy, is_shift, is_update, last_bit, reset_end;
    logic start_acc, more_words, go, done_scan, sen_int, tms_int, sen_lat;

    assign rst        = rst_sync || cfg.soft_rst;
    assign is_shift   = (state == jtag_master_pkg::shift_dr) || (state == jtag_master_pkg::shift_ir);
    assign is_update  = (state == jtag_master_pkg::update_dr) ||
                        (state == jtag_master_pkg::update_ir);
    assign last_bit   = bit_cnt == cfg.bit_count - 16'd1;
    assign reset_end  = (state == jtag_master_pkg::test_logic_reset) &&
                        (reset_cnt == 3'(`JM_TLR_CYCLES - 1));
    assign start_acc  = (state == jtag_master_pkg::run_test_idle) && cfg.start && !busy;
    assign more_words = busy && (word_cnt != cfg.word_count);
    assign go         = (start_acc && cfg.word_count != 16'd0) || more_words;
    assign done_scan  = (state == jtag_master_pkg::run_test_idle) && busy && !more_words;
    assign sen_int    = (state != jtag_master_pkg::run_test_idle) || go;
    assign cfg.done   = done_scan || reset_end;

    always_comb
    begin
        next_state = state;
        case (state)
            jtag_master_pkg::test_logic_reset:
                if (reset_end) next_state = jtag_master_pkg::run_test_idle;
            jtag_master_pkg::run_test_idle:
                if (go) next_state = jtag_master_pkg::select_dr;
            jtag_master_pkg::select_dr:
                next_state = (cfg.opcode == jtag_master_pkg::dr_scan) ?
                             jtag_master_pkg::capture_dr : jtag_master_pkg::select_ir;
            jtag_master_pkg::capture_dr: next_state = jtag_master_pkg::shift_dr;
            jtag_master_pkg::shift_dr:
                if (last_bit) next_state = jtag_master_pkg::exit1_dr;
            jtag_master_pkg::exit1_dr:   next_state = jtag_master_pkg::update_dr;
            jtag_master_pkg::select_ir:  next_state = jtag_master_pkg::capture_ir;
            jtag_master_pkg::capture_ir: next_state = jtag_master_pkg::shift_ir;
            jtag_master_pkg::shift_ir:
                if (last_bit) next_state = jtag_master_pkg::exit1_ir;
            jtag_master_pkg::exit1_ir:   next_state = jtag_master_pkg::update_ir;
            jtag_master_pkg::update_dr,
            jtag_master_pkg::update_ir:  next_state = jtag_master_pkg::run_test_idle;
            default:                     next_state = jtag_master_pkg::test_logic_reset;
        endcase
    end

    // TMS is 1 when the step takes the TMS=1 branch of the TAP graph
    always_comb
    begin
        case (state)
            jtag_master_pkg::test_logic_reset:
                tms_int = next_state == jtag_master_pkg::test_logic_reset;
            jtag_master_pkg::run_test_idle, jtag_master_pkg::update_dr, jtag_master_pkg::update_ir:
                tms_int = next_state == jtag_master_pkg::select_dr;
            jtag_master_pkg::select_dr:
                tms_int = next_state == jtag_master_pkg::select_ir;
            jtag_master_pkg::select_ir:
                tms_int = next_state == jtag_master_pkg::test_logic_reset;
            jtag_master_pkg::capture_dr, jtag_master_pkg::shift_dr:
                tms_int = next_state == jtag_master_pkg::exit1_dr;
            jtag_master_pkg::capture_ir, jtag_master_pkg::shift_ir:
                tms_int = next_state == jtag_master_pkg::exit1_ir;
            jtag_master_pkg::exit1_dr: tms_int = next_state == jtag_master_pkg::update_dr;
            jtag_master_pkg::exit1_ir: tms_int = next_state == jtag_master_pkg::update_ir;
            default:                   tms_int = 1'b1;
        endcase
    end

    always_ff @(posedge jtag_clk)
    begin
        if (rst)
        begin
            state     <= jtag_master_pkg::test_logic_reset;
            reset_cnt <= 3'd0;
            bit_cnt   <= 16'd0;
            word_cnt  <= 16'd0;
            busy      <= 1'b0;
            sen_hist  <= 2'b00;
            sld       <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            reset_cnt <= (state == jtag_master_pkg::test_logic_reset) ? reset_cnt + 3'd1 : 3'd0;
            bit_cnt   <= is_shift ? bit_cnt + 16'd1 : 16'd0;
            if (start_acc)
                word_cnt <= 16'd0;
            else if (is_update)
                word_cnt <= word_cnt + 16'd1;
            if (start_acc)
                busy <= 1'b1;
            else if (done_scan)
                busy <= 1'b0;
            sen_hist  <= {sen_hist[0], sen_int};
            sld       <= sen_hist[1] && !sen_hist[0];   // Two cycles after the last TCK
        end
    end

    // Highest index of the word goes out first
    assign addr_full = 32'(word_cnt) * 32'(cfg.bit_count) + 32'(cfg.bit_count) - 32'd1
                       - 32'(bit_cnt);
    assign scan.bit_addr = jtag_master_pkg::bit_addr_t'(addr_full);
    assign scan.cap_en   = is_shift;
    assign scan.cap_bit  = tdo;

    always_ff @(negedge jtag_clk)
    begin
        if (rst)
        begin
            sen <= 1'b0;
            tms <= 1'b0;
            tdi <= 1'b0;
        end
        else
        begin
            sen <= sen_int;
            tms <= tms_int;
            tdi <= is_shift ? scan.tdi_bit : 1'b0;
        end
    end

    // Clock gate, enable held while the clock is high
    always_latch
    begin
        if (!jtag_clk)
            sen_lat <= sen;
    end

    assign tck = jtag_clk & sen_lat;

    a_no_pause: assert property (
        @(posedge jtag_clk)
        !(state inside {jtag_master_pkg::pause_dr, jtag_master_pkg::pause_ir})
    );

    // Falling-edge TMS must already leave Shift on the last bit
    a_tms_last_bit: assert property (
        @(posedge jtag_clk) disable iff (rst) (is_shift && last_bit) |-> tms
    );

endmodule

// File: verilog/jtag_master.sv
// JTAG master core top; one clock for bus and scan, no handshake on the bus strobes
`timescale 1ns/1ps

module jtag_master (
    input  logic                       jtag_clk,
    input  logic                       rst_sync,
    input  jtag_master_pkg::bus_addr_t bus_add,
    input  jtag_master_pkg::bus_byte_t bus_data_in,
    input  logic                       bus_rd,
    input  logic                       bus_wr,
    output jtag_master_pkg::bus_byte_t bus_data_out,
    output logic                       tck,
    output logic                       tms,
    output logic                       tdi,
    input  logic                       tdo,
    output logic                       sen,
    output logic                       sld
);

    jtag_master_pkg::bus_byte_t tdo_byte;   // Memory byte at bus_add

    jtag_cfg_if  cfg_if ();
    jtag_scan_if scan_if ();

    jtag_master_regs u_regs (
        .jtag_clk     (jtag_clk),
        .rst_sync     (rst_sync),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .bus_rd       (bus_rd),
        .bus_data_out (bus_data_out),
        .tdo_byte     (tdo_byte),
        .cfg          (cfg_if.regs)
    );

    jtag_scan_mem u_mem (
        .jtag_clk    (jtag_clk),
        .bus_add     (bus_add),
        .bus_data_in (bus_data_in),
        .bus_wr      (bus_wr),
        .tdo_byte    (tdo_byte),
        .scan        (scan_if.mem)
    );

    jtag_tap_ctrl u_tap (
        .jtag_clk (jtag_clk),
        .rst_sync (rst_sync),
        .cfg      (cfg_if.tap),
        .scan     (scan_if.tap),
        .tdo      (tdo),
        .tck      (tck),
        .tms      (tms),
        .tdi      (tdi),
        .sen      (sen),
        .sld      (sld)
    );

endmodule

// File: tests/jtag_master_tb.sv
// Loopback target of 3 stages; scans must fit the scan memory, run ends at 4000 clock cycles
`timescale 1ns/1ps
`include "jtag_master_defines.svh"

module jtag_master_tb;

    typedef logic bit_q_t [$];

    logic jtag_clk, rst_sync, bus_rd, bus_wr, tck, tms, tdi, tdo, sen, sld;
    jtag_master_pkg::bus_addr_t  bus_add;
    jtag_master_pkg::bus_byte_t  bus_data_in, bus_data_out;
    jtag_master_pkg::tap_state_t obs_state;
    logic [2:0] sr;                       // Target shift register
    logic       tdi_model [`JM_MEM_BITS];
    bit_q_t     tms_q, tdi_q;
    int         cycles, sld_count;
    int         seed = 32'h3a92_28de;

    jtag_master u_dut (
        .jtag_clk(jtag_clk), .rst_sync(rst_sync), .bus_add(bus_add),
        .bus_data_in(bus_data_in), .bus_rd(bus_rd), .bus_wr(bus_wr),
        .bus_data_out(bus_data_out), .tck(tck), .tms(tms), .tdi(tdi),
        .tdo(tdo), .sen(sen), .sld(sld)
    );

    initial
    begin
        jtag_clk = 1'b0;
        forever #20 jtag_clk = ~jtag_clk;
    end

    always @(posedge jtag_clk)
    begin
        cycles <= cycles + 1;
        if (sld)
            sld_count <= sld_count + 1;
        if (cycles >= 4000)
        begin
            $display("timeout: the run did not finish within 4000 cycles");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // Standard TAP graph, Pause states included
    function automatic jtag_master_pkg::tap_state_t next_tap(
        input jtag_master_pkg::tap_state_t s, input logic m);
        case (s)
            jtag_master_pkg::test_logic_reset:
                return m ? jtag_master_pkg::test_logic_reset : jtag_master_pkg::run_test_idle;
            jtag_master_pkg::run_test_idle, jtag_master_pkg::update_dr,
            jtag_master_pkg::update_ir:
                return m ? jtag_master_pkg::select_dr : jtag_master_pkg::run_test_idle;
            jtag_master_pkg::select_dr:
                return m ? jtag_master_pkg::select_ir : jtag_master_pkg::capture_dr;
            jtag_master_pkg::capture_dr, jtag_master_pkg::shift_dr, jtag_master_pkg::exit2_dr:
                return m ? jtag_master_pkg::exit1_dr : jtag_master_pkg::shift_dr;
            jtag_master_pkg::exit1_dr, jtag_master_pkg::pause_dr:
                return m ? jtag_master_pkg::update_dr : jtag_master_pkg::pause_dr;
            jtag_master_pkg::select_ir:
                return m ? jtag_master_pkg::test_logic_reset : jtag_master_pkg::capture_ir;
            jtag_master_pkg::capture_ir, jtag_master_pkg::shift_ir, jtag_master_pkg::exit2_ir:
                return m ? jtag_master_pkg::exit1_ir : jtag_master_pkg::shift_ir;
            default:
                return m ? jtag_master_pkg::update_ir : jtag_master_pkg::pause_ir;
        endcase
    endfunction

    // Target side, reset pin masks X edges at power up
    always @(posedge tck)
    begin
        if (!rst_sync)
        begin
            if (obs_state inside {jtag_master_pkg::shift_dr, jtag_master_pkg::shift_ir})
            begin
                tdi_q.push_back(tdi);
                sr <= {sr[1:0], tdi};
            end
            tms_q.push_back(tms);
            obs_state <= next_tap(obs_state, tms);
        end
    end

    always @(negedge tck) tdo <= sr[2];

    function automatic bit_q_t expected_tms(input int op, input int bc, input int wc);
        bit_q_t q;
        for (int w = 0; w < wc; w++)
        begin
            q.push_back(1'b1);
            if (op == 0)
                q.push_back(1'b1);                 // Select-IR
            q.push_back(1'b0);
            q.push_back(1'b0);
            for (int j = 0; j < bc; j++)
                q.push_back(j == bc - 1);
            q.push_back(1'b1);
            q.push_back(1'b0);
        end
        return q;
    endfunction

    // Memory index of the k-th shifted bit
    function automatic int shift_index(input int k, input int bc);
        return (k / bc) * bc + bc - 1 - (k % bc);
    endfunction

    function automatic bit_q_t expected_tdi(input int bc, input int wc);
        bit_q_t q;
        for (int k = 0; k < bc * wc; k++)
            q.push_back(tdi_model[shift_index(k, bc)]);
        return q;
    endfunction

    function automatic bit_q_t expected_tdo_mem(input int bc, input int wc);
        bit_q_t sent;
        bit_q_t mem;
        sent = expected_tdi(bc, wc);
        for (int i = 0; i < bc * wc; i++)
            mem.push_back(1'b0);
        for (int k = 3; k < bc * wc; k++)
            mem[shift_index(k, bc)] = sent[k - 3];
        return mem;
    endfunction

    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp)
        else
        begin
            $display("mismatch at %0t ns: %s read %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic bus_write(input int addr, input int data);
        @(posedge jtag_clk);
        #2;
        bus_add     = 16'(addr);
        bus_data_in = 8'(data);
        bus_wr      = 1'b1;
        @(posedge jtag_clk);
        #2;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input int addr, output int data);
        @(posedge jtag_clk);
        #2;
        bus_add = 16'(addr);
        bus_rd  = 1'b1;
        @(posedge jtag_clk);
        #2;
        bus_rd = 1'b0;
        data   = int'(bus_data_out);
    endtask

    task automatic wait_done();
        int d;
        d = 0;
        while (d[0] == 1'b0)
            bus_read(`JM_REG_START, d);
    endtask

    task automatic configure(input int op, input int bc, input int wc);
        bus_write(`JM_REG_BITS_LO, bc & 8'hff);
        bus_write(`JM_REG_BITS_HI, bc >> 8);
        bus_write(`JM_REG_WORDS_LO, wc & 8'hff);
        bus_write(`JM_REG_WORDS_HI, wc >> 8);
        bus_write(`JM_REG_OPCODE, op);
    endtask

    task automatic check_queue(input bit_q_t got, input bit_q_t exp, input string what);
        check_value(got.size(), exp.size(), {what, " length"});
        for (int i = 0; i < exp.size(); i++)
            check_value(int'(got[i]), int'(exp[i]), $sformatf("%s bit %0d", what, i));
    endtask

    task automatic run_scan(input int op, input int bc, input int wc);
        int     d, b;
        bit_q_t mem;
        for (int n = 0; n < (bc * wc + 7) / 8; n++)
        begin
            b = $random(seed) & 8'hff;
            for (int p = 0; p < 8; p++)
                tdi_model[8 * n + p] = b[7 - p];   // First bit is the MSB
            bus_write(`JM_TDI_BASE + n, b);
        end
        configure(op, bc, wc);
        tms_q.delete();
        tdi_q.delete();
        sr        = 3'b000;
        sld_count = 0;
        bus_write(`JM_REG_START, 0);
        wait_done();
        check_value(int'(sen), 0, "sen in idle");
        check_value(int'(tms), 0, "tms in idle");
        check_value(int'(tdi), 0, "tdi in idle");
        check_queue(tms_q, expected_tms(op, bc, wc), "tms");
        check_queue(tdi_q, expected_tdi(bc, wc), "tdi");
        mem = expected_tdo_mem(bc, wc);
        for (int n = 0; n < (bc * wc) / 8; n++)
        begin
            bus_read(`JM_TDO_BASE + n, d);
            for (int p = 0; p < 8; p++)
                b[7 - p] = mem[8 * n + p];
            check_value(d, b & 8'hff, $sformatf("tdo byte %0d", n));
        end
    endtask

    initial
    begin
        int     d;
        bit_q_t rst_seq;
        rst_seq     = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
        rst_sync    = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        tdo         = 1'b0;
        sr          = 3'b000;
        cycles      = 0;
        sld_count   = 0;
        obs_state   = jtag_master_pkg::test_logic_reset;
        repeat (4) @(posedge jtag_clk);
        #2;
        rst_sync = 1'b0;

        wait_done();
        check_queue(tms_q, rst_seq, "reset tms");

        bus_read(`JM_REG_RST, d);
        check_value(d, `JM_VERSION, "version");
        bus_read(`JM_REG_MEMSZ_LO, d);
        check_value(d, `JM_MEM_BYTES, "memory size");
        bus_read(`JM_REG_MEMSZ_HI, d);
        check_value(d, 0, "memory size high");
        bus_read(`JM_REG_BITS_LO, d);
        check_value(d, (8 * `JM_MEM_BYTES) & 8'hff, "bit count reset");
        bus_read(`JM_REG_BITS_HI, d);
        check_value(d, (8 * `JM_MEM_BYTES) >> 8, "bit count reset high");
        bus_read(`JM_REG_WORDS_LO, d);
        check_value(d, 1, "word count reset");
        bus_read(`JM_REG_WORDS_HI, d);
        check_value(d, 0, "word count reset high");
        bus_read(`JM_REG_OPCODE, d);
        check_value(d, 1, "opcode reset");
        configure(0, 16'h1234, 16'h0205);
        bus_read(`JM_REG_BITS_LO, d);
        check_value(d, 8'h34, "bit count low");
        bus_read(`JM_REG_BITS_HI, d);
        check_value(d, 8'h12, "bit count high");
        bus_read(`JM_REG_WORDS_LO, d);
        check_value(d, 8'h05, "word count low");
        bus_read(`JM_REG_WORDS_HI, d);
        check_value(d, 8'h02, "word count high");
        bus_read(`JM_REG_OPCODE, d);
        check_value(d, 0, "opcode");

        run_scan(1, 16, 1);

        run_scan(0, 8, 3);
        while (sld_count == 0)
            @(posedge jtag_clk);
        repeat (4) @(posedge jtag_clk);
        check_value(sld_count, 1, "sld pulses");

        // Soft reset in the middle of a long DR scan
        configure(1, 16, 3);
        tdi_q.delete();
        bus_write(`JM_REG_START, 0);
        while (tdi_q.size() < 5)
            @(posedge jtag_clk);
        bus_write(`JM_REG_RST, 0);
        tms_q.delete();
        wait_done();
        check_queue(tms_q, rst_seq, "soft reset tms");
        run_scan(1, 16, 1);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: jtag_master.f
+incdir+verilog
verilog/jtag_master_pkg.sv
verilog/jtag_master_if.sv
verilog/jtag_master_regs.sv
verilog/jtag_scan_mem.sv
verilog/jtag_tap_ctrl.sv
verilog/jtag_master.sv
tests/jtag_master_tb.sv

// File: Makefile
TOP = jtag_master_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f jtag_master.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
